/* Makefile */
# Verilator flow for the reorder cluster testbench
TOP := tb_rob_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

# The binary exits non-zero on $fatal or a failed assertion
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* build.f */
rob_pkg.sv
reorder_buffer.sv
request_dispatch.sv
compute_lane.sv
result_collect.sv
rob_subsystem.sv
rob_subsystem_props.sv
tb_rob_subsystem.sv

/* compute_lane.sv */
// One compute lane: small request queue feeding an FSM with opcode-dependent latency
// Returns a credit on every pop and holds its result until the collector grants it
module compute_lane #(
  parameter int DATA_WIDTH  = 16,
  parameter int INDEX_WIDTH = 3,
  parameter int LANE_DEPTH  = 2
) (
  input  logic                   clock,
  input  logic                   resetn,
  input  logic                   issue_valid,
  input  rob_pkg::rob_op_t       issue_opcode,
  input  logic [DATA_WIDTH-1:0]  issue_operand_a,
  input  logic [DATA_WIDTH-1:0]  issue_operand_b,
  input  logic [INDEX_WIDTH-1:0] issue_index,
  input  logic                   done_grant,
  output logic                   credit_return,
  output logic                   done_valid,
  output logic [INDEX_WIDTH-1:0] done_index,
  output logic [DATA_WIDTH-1:0]  done_data
);

  import rob_pkg::*;

  localparam int PTR_WIDTH   = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(LANE_DEPTH + 1);

  // Request queue
  rob_op_t                q_opcode    [LANE_DEPTH];
  logic [DATA_WIDTH-1:0]  q_operand_a [LANE_DEPTH];
  logic [DATA_WIDTH-1:0]  q_operand_b [LANE_DEPTH];
  logic [INDEX_WIDTH-1:0] q_index     [LANE_DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] q_count;
  logic                   pop;

  // Request in execution
  lane_state_t            state;
  logic [2:0]             busy_count;
  rob_op_t                cur_opcode;
  logic [DATA_WIDTH-1:0]  cur_operand_a;
  logic [DATA_WIDTH-1:0]  cur_operand_b;
  logic [INDEX_WIDTH-1:0] cur_index;
  logic [DATA_WIDTH-1:0]  result;

  // Pop only when idle and something is queued
  assign pop           = (state == LANE_IDLE) && (q_count != '0);
  assign credit_return = pop;
  assign done_valid    = state == LANE_DONE;
  assign done_index    = cur_index;
  assign done_data     = result;

  // Queue entries and execution payload
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      q_opcode[wr_ptr]    <= issue_opcode;
      q_operand_a[wr_ptr] <= issue_operand_a;
      q_operand_b[wr_ptr] <= issue_operand_b;
      q_index[wr_ptr]     <= issue_index;
    end
    if (pop) begin
      cur_opcode    <= q_opcode[rd_ptr];
      cur_operand_a <= q_operand_a[rd_ptr];
      cur_operand_b <= q_operand_b[rd_ptr];
      cur_index     <= q_index[rd_ptr];
    end
    // Result captured on the last busy cycle
    if (state == LANE_BUSY && busy_count == 3'd1) begin
      result <= op_result(cur_opcode, cur_operand_a, cur_operand_b);
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_count    <= '0;
      state      <= LANE_IDLE;
      busy_count <= '0;
    end else begin
      if (issue_valid) begin
        wr_ptr <= (int'(wr_ptr) == LANE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == LANE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + COUNT_WIDTH'(issue_valid) - COUNT_WIDTH'(pop);
      case (state)
        LANE_IDLE: begin
          if (pop) begin
            state      <= LANE_BUSY;
            busy_count <= op_latency(q_opcode[rd_ptr]);
          end
        end
        LANE_BUSY: begin
          busy_count <= busy_count - 1'b1;
          if (busy_count == 3'd1) begin
            state <= LANE_DONE;
          end
        end
        // Wait for the collector
        LANE_DONE: begin
          if (done_grant) begin
            state <= LANE_IDLE;
          end
        end
        default: state <= LANE_IDLE;
      endcase
    end
  end

endmodule

/* reorder_buffer.sv */
// Reorder buffer with slots reserved in order, written by index and drained in order
// Any misuse of the three ports latches the sticky protocol error
module reorder_buffer #(
  parameter int DATA_WIDTH  = 16,
  parameter int INDEX_WIDTH = 3
) (
  input  logic                   clock,
  input  logic                   resetn,
  input  logic                   reserve_enable,
  input  logic                   write_enable,
  input  logic [INDEX_WIDTH-1:0] write_index,
  input  logic [DATA_WIDTH-1:0]  write_data,
  input  logic                   read_enable,
  output logic                   reserve_full,
  output logic                   reserve_empty,
  output logic                   data_full,
  output logic                   data_empty,
  output logic [INDEX_WIDTH-1:0] reserve_index,
  output logic                   read_valid,
  output logic [DATA_WIDTH-1:0]  read_data,
  output logic                   protocol_error
);

  localparam int DEPTH = 1 << INDEX_WIDTH;

  // Slot storage
  logic [DATA_WIDTH-1:0] slot_data [DEPTH];

  // Per-slot reserved and valid bits
  logic [DEPTH-1:0] reserved;
  logic [DEPTH-1:0] reserved_next;
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;

  // Pointers carry one extra wrap bit
  logic [INDEX_WIDTH:0] reserve_ptr;
  logic [INDEX_WIDTH:0] reserve_ptr_next;
  logic [INDEX_WIDTH:0] read_ptr;
  logic [INDEX_WIDTH:0] read_ptr_next;
  logic [INDEX_WIDTH-1:0] head;

  logic reserve_error;
  logic write_error;
  logic read_error;

  assign head          = read_ptr[INDEX_WIDTH-1:0];
  assign reserve_index = reserve_ptr[INDEX_WIDTH-1:0];
  assign read_valid    = valid[head];
  assign read_data     = slot_data[head];

  // Misuse of each port
  assign reserve_error = reserve_enable && reserve_full;
  assign write_error   = write_enable && (valid[write_index] || !reserved[write_index]);
  assign read_error    = read_enable && !read_valid;

  // Next-state bookkeeping for all three ports
  always_comb begin
    reserved_next    = reserved;
    valid_next       = valid;
    reserve_ptr_next = reserve_ptr;
    read_ptr_next    = read_ptr;
    if (reserve_enable) begin
      reserved_next[reserve_index] = 1'b1;
      reserve_ptr_next             = reserve_ptr + 1'b1;
    end
    if (write_enable) begin
      valid_next[write_index] = 1'b1;
    end
    // Head slot released on read
    if (read_enable) begin
      valid_next[head]    = 1'b0;
      reserved_next[head] = 1'b0;
      read_ptr_next       = read_ptr + 1'b1;
    end
  end

  // Slot payload
  always_ff @(posedge clock) begin
    if (write_enable) begin
      slot_data[write_index] <= write_data;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserved       <= '0;
      valid          <= '0;
      reserve_ptr    <= '0;
      read_ptr       <= '0;
      reserve_full   <= 1'b0;
      reserve_empty  <= 1'b1;
      data_full      <= 1'b0;
      data_empty     <= 1'b1;
      protocol_error <= 1'b0;
    end else begin
      reserved    <= reserved_next;
      valid       <= valid_next;
      reserve_ptr <= reserve_ptr_next;
      read_ptr    <= read_ptr_next;
      // Flags follow the next-state pointers
      reserve_full  <= (reserve_ptr_next[INDEX_WIDTH-1:0] == read_ptr_next[INDEX_WIDTH-1:0])
                    && (reserve_ptr_next[INDEX_WIDTH] != read_ptr_next[INDEX_WIDTH]);
      reserve_empty <= reserve_ptr_next == read_ptr_next;
      data_full     <= &valid_next;
      data_empty    <= ~|valid_next;
      // Sticky once set
      protocol_error <= protocol_error | reserve_error | write_error | read_error;
    end
  end

endmodule

/* request_dispatch.sv */
// Dispatcher: accepts requests, reserves a reorder slot and issues to a lane with credit
// Lane choice is round robin, credits come back from the lanes on queue pop
module request_dispatch #(
  parameter int DATA_WIDTH  = 16,
  parameter int INDEX_WIDTH = 3,
  parameter int NUM_LANES   = 4,
  parameter int LANE_DEPTH  = 2
) (
  input  logic                   clock,
  input  logic                   resetn,
  input  logic                   in_valid,
  input  rob_pkg::rob_op_t       in_opcode,
  input  logic [DATA_WIDTH-1:0]  in_operand_a,
  input  logic [DATA_WIDTH-1:0]  in_operand_b,
  input  logic                   reserve_full,
  input  logic [INDEX_WIDTH-1:0] reserve_index,
  input  logic [NUM_LANES-1:0]   credit_return,
  output logic                   in_ready,
  output logic                   reserve_enable,
  output logic [NUM_LANES-1:0]   issue_valid,
  output rob_pkg::rob_op_t       issue_opcode,
  output logic [DATA_WIDTH-1:0]  issue_operand_a,
  output logic [DATA_WIDTH-1:0]  issue_operand_b,
  output logic [INDEX_WIDTH-1:0] issue_index
);

  localparam int LANE_WIDTH   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int CREDIT_WIDTH = $clog2(LANE_DEPTH + 1);

  // Free queue entries per lane
  logic [CREDIT_WIDTH-1:0] credit [NUM_LANES];
  logic [NUM_LANES-1:0]    has_credit;

  logic [LANE_WIDTH-1:0] rr_ptr;
  logic [LANE_WIDTH-1:0] sel_lane;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      has_credit[l] = credit[l] != '0;
    end
  end

  // First lane with credit at or after the pointer
  always_comb begin
    int cand;
    logic found;
    found    = 1'b0;
    sel_lane = rr_ptr;
    for (int i = 0; i < NUM_LANES; i++) begin
      cand = (int'(rr_ptr) + i) % NUM_LANES;
      if (!found && has_credit[cand]) begin
        found    = 1'b1;
        sel_lane = LANE_WIDTH'(cand);
      end
    end
  end

  // Need a free slot and some lane with room
  assign in_ready       = !reserve_full && (|has_credit);
  assign reserve_enable = in_valid && in_ready;
  assign issue_valid    = reserve_enable ? (NUM_LANES'(1) << sel_lane) : '0;

  // Request goes out the same cycle, tagged with its slot
  assign issue_opcode    = in_opcode;
  assign issue_operand_a = in_operand_a;
  assign issue_operand_b = in_operand_b;
  assign issue_index     = reserve_index;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      rr_ptr <= '0;
      for (int l = 0; l < NUM_LANES; l++) begin
        credit[l] <= CREDIT_WIDTH'(LANE_DEPTH);
      end
    end else begin
      // Return and issue may land together
      for (int l = 0; l < NUM_LANES; l++) begin
        credit[l] <= credit[l] + CREDIT_WIDTH'(credit_return[l])
                   - CREDIT_WIDTH'(issue_valid[l]);
      end
      if (reserve_enable) begin
        rr_ptr <= (int'(sel_lane) == NUM_LANES - 1) ? '0 : sel_lane + 1'b1;
      end
    end
  end

endmodule

/* result_collect.sv */
// Round-robin collector from the finished lanes into the reorder buffer write port
// Grants one lane per cycle and writes its result in the same cycle
module result_collect #(
  parameter int DATA_WIDTH  = 16,
  parameter int INDEX_WIDTH = 3,
  parameter int NUM_LANES   = 4
) (
  input  logic                             clock,
  input  logic                             resetn,
  input  logic [NUM_LANES-1:0]             done_valid,
  input  logic [NUM_LANES*INDEX_WIDTH-1:0] done_index,
  input  logic [NUM_LANES*DATA_WIDTH-1:0]  done_data,
  output logic [NUM_LANES-1:0]             done_grant,
  output logic                             write_enable,
  output logic [INDEX_WIDTH-1:0]           write_index,
  output logic [DATA_WIDTH-1:0]            write_data
);

  localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [LANE_WIDTH-1:0] rr_ptr;
  logic [LANE_WIDTH-1:0] winner;
  logic                  found;

  // First done lane at or after the pointer
  always_comb begin
    int cand;
    found  = 1'b0;
    winner = rr_ptr;
    for (int i = 0; i < NUM_LANES; i++) begin
      cand = (int'(rr_ptr) + i) % NUM_LANES;
      if (!found && done_valid[cand]) begin
        found  = 1'b1;
        winner = LANE_WIDTH'(cand);
      end
    end
  end

  assign done_grant   = found ? (NUM_LANES'(1) << winner) : '0;
  assign write_enable = found;
  // Winner's slice of the flattened buses
  assign write_index  = done_index[winner*INDEX_WIDTH +: INDEX_WIDTH];
  assign write_data   = done_data[winner*DATA_WIDTH +: DATA_WIDTH];

  // Winner drops to lowest priority
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      rr_ptr <= '0;
    end else if (found) begin
      rr_ptr <= (int'(winner) == NUM_LANES - 1) ? '0 : winner + 1'b1;
    end
  end

endmodule

/* rob_pkg.sv */
// Shared opcode and lane state types, plus the per-opcode latency and result functions
// Imported by the lanes, the top level and the testbench
package rob_pkg;

  // Request opcodes
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_XOR = 2'd1,
    OP_MUL = 2'd2
  } rob_op_t;

  // Compute lane FSM states
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,
    LANE_BUSY = 2'd1,
    LANE_DONE = 2'd2
  } lane_state_t;

  // Busy cycles spent per opcode
  function automatic logic [2:0] op_latency(input rob_op_t op);
    case (op)
      OP_ADD:  return 3'd1;
      OP_XOR:  return 3'd2;
      OP_MUL:  return 3'd4;
      default: return 3'd1;
    endcase
  endfunction

  // Result of one request, truncated to 16 bits
  function automatic logic [15:0] op_result(input rob_op_t op, input logic [15:0] a,
                                            input logic [15:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_XOR:  return a ^ b;
      // Low half of the product
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

endpackage

/* rob_stimulus.txt */
# opcode operand_a operand_b expected_result, all hex
# opcode 0 is add, 1 is xor, 2 is multiply
2 1234 0003 369c
0 0001 0002 0003
0 ffff 0002 0001
1 a5a5 0ff0 aa55
2 0100 0100 0000
0 7000 1234 8234
2 00ff 00ff fe01
0 1111 2222 3333
1 ffff 1234 edcb
2 0012 0034 03a8
0 8000 8000 0000
1 0f0f f0f0 ffff
2 0200 0030 6000
0 00aa 0055 00ff
2 ffff ffff 0001
1 1234 1234 0000
0 abcd 1111 bcde
2 0007 0009 003f

/* rob_subsystem.sv */
// Out-of-order cluster top: dispatcher, compute lanes, collector and reorder buffer
// Requests go in through valid/ready and come out in the same order
module rob_subsystem #(
  parameter int DATA_WIDTH  = 16,
  parameter int ROB_DEPTH   = 8,
  parameter int INDEX_WIDTH = $clog2(ROB_DEPTH),
  parameter int NUM_LANES   = 4,
  parameter int LANE_DEPTH  = 2
) (
  input  logic                  clock,
  input  logic                  resetn,
  input  logic                  in_valid,
  input  rob_pkg::rob_op_t      in_opcode,
  input  logic [DATA_WIDTH-1:0] in_operand_a,
  input  logic [DATA_WIDTH-1:0] in_operand_b,
  input  logic                  out_ready,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_result,
  output logic                  protocol_error
);

  import rob_pkg::*;

  // Dispatch side
  logic                   reserve_enable;
  logic                   reserve_full;
  logic [INDEX_WIDTH-1:0] reserve_index;
  logic [NUM_LANES-1:0]   issue_valid;
  rob_op_t                issue_opcode;
  logic [DATA_WIDTH-1:0]  issue_operand_a;
  logic [DATA_WIDTH-1:0]  issue_operand_b;
  logic [INDEX_WIDTH-1:0] issue_index;
  logic [NUM_LANES-1:0]   credit_return;

  // Completion side, flattened per lane
  logic [NUM_LANES-1:0]             done_valid;
  logic [NUM_LANES-1:0]             done_grant;
  logic [NUM_LANES*INDEX_WIDTH-1:0] done_index;
  logic [NUM_LANES*DATA_WIDTH-1:0]  done_data;
  logic                             write_enable;
  logic [INDEX_WIDTH-1:0]           write_index;
  logic [DATA_WIDTH-1:0]            write_data;

  request_dispatch #(
    .DATA_WIDTH  (DATA_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH),
    .NUM_LANES   (NUM_LANES),
    .LANE_DEPTH  (LANE_DEPTH)
  ) u_request_dispatch (
    .clock           (clock),
    .resetn          (resetn),
    .in_valid        (in_valid),
    .in_opcode       (in_opcode),
    .in_operand_a    (in_operand_a),
    .in_operand_b    (in_operand_b),
    .reserve_full    (reserve_full),
    .reserve_index   (reserve_index),
    .credit_return   (credit_return),
    .in_ready        (in_ready),
    .reserve_enable  (reserve_enable),
    .issue_valid     (issue_valid),
    .issue_opcode    (issue_opcode),
    .issue_operand_a (issue_operand_a),
    .issue_operand_b (issue_operand_b),
    .issue_index     (issue_index)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    compute_lane #(
      .DATA_WIDTH  (DATA_WIDTH),
      .INDEX_WIDTH (INDEX_WIDTH),
      .LANE_DEPTH  (LANE_DEPTH)
    ) u_compute_lane (
      .clock           (clock),
      .resetn          (resetn),
      .issue_valid     (issue_valid[l]),
      .issue_opcode    (issue_opcode),
      .issue_operand_a (issue_operand_a),
      .issue_operand_b (issue_operand_b),
      .issue_index     (issue_index),
      .done_grant      (done_grant[l]),
      .credit_return   (credit_return[l]),
      .done_valid      (done_valid[l]),
      .done_index      (done_index[l*INDEX_WIDTH +: INDEX_WIDTH]),
      .done_data       (done_data[l*DATA_WIDTH +: DATA_WIDTH])
    );
  end

  result_collect #(
    .DATA_WIDTH  (DATA_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH),
    .NUM_LANES   (NUM_LANES)
  ) u_result_collect (
    .clock        (clock),
    .resetn       (resetn),
    .done_valid   (done_valid),
    .done_index   (done_index),
    .done_data    (done_data),
    .done_grant   (done_grant),
    .write_enable (write_enable),
    .write_index  (write_index),
    .write_data   (write_data)
  );

  // Reads only on an output handshake
  reorder_buffer #(
    .DATA_WIDTH  (DATA_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_reorder_buffer (
    .clock          (clock),
    .resetn         (resetn),
    .reserve_enable (reserve_enable),
    .write_enable   (write_enable),
    .write_index    (write_index),
    .write_data     (write_data),
    .read_enable    (out_valid && out_ready),
    .reserve_full   (reserve_full),
    .reserve_empty  (),
    .data_full      (),
    .data_empty     (),
    .reserve_index  (reserve_index),
    .read_valid     (out_valid),
    .read_data      (out_result),
    .protocol_error (protocol_error)
  );

endmodule

/* rob_subsystem_props.sv */
// Concurrent checks bound into the cluster top
// Cover input ready against a full buffer, lane issue, buffer errors and reset
module rob_subsystem_props #(
  parameter int NUM_LANES = 4
) (
  input logic                 clock,
  input logic                 resetn,
  input logic                 in_ready,
  input logic                 reserve_full,
  input logic [NUM_LANES-1:0] issue_valid,
  input logic                 out_valid,
  input logic                 protocol_error
);

  // No new request once every slot is reserved
  a_ready_when_full: assert property (
    @(posedge clock) disable iff (!resetn) reserve_full |-> !in_ready
  ) else $error("in_ready high while all reorder slots are reserved");

  // One credit spent on one lane per cycle at most
  a_issue_onehot: assert property (
    @(posedge clock) disable iff (!resetn) $onehot0(issue_valid)
  ) else $error("issue_valid selects more than one lane");

  // Buffer sees only legal reserve, write and read traffic
  a_no_protocol_error: assert property (
    @(posedge clock) disable iff (!resetn) !protocol_error
  ) else $error("protocol_error set by the reorder buffer");

  // Output stays quiet in reset
  a_quiet_in_reset: assert property (
    @(posedge clock) !resetn |-> !out_valid
  ) else $error("out_valid high during reset");

endmodule

bind rob_subsystem rob_subsystem_props #(
  .NUM_LANES (NUM_LANES)
) u_rob_subsystem_props (
  .clock          (clock),
  .resetn         (resetn),
  .in_ready       (in_ready),
  .reserve_full   (reserve_full),
  .issue_valid    (issue_valid),
  .out_valid      (out_valid),
  .protocol_error (protocol_error)
);

/* tb_rob_subsystem.sv */
// Testbench for the reorder cluster: replays the stimulus file with random gaps and stalls
// Results must leave in request order, matching the expected column of the file
module tb_rob_subsystem;

  import rob_pkg::*;

  localparam int DATA_WIDTH   = 16;
  localparam int ROB_DEPTH    = 8;
  localparam int BURST_START  = 6;
  localparam int STALL_CYCLES = 40;
  localparam int TIMEOUT      = 200;

  logic                  clock;
  logic                  resetn;
  logic                  in_valid;
  rob_op_t               in_opcode;
  logic [DATA_WIDTH-1:0] in_operand_a;
  logic [DATA_WIDTH-1:0] in_operand_b;
  logic                  out_ready;
  logic                  in_ready;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_result;
  logic                  protocol_error;

  // Requests and expected results in file order
  rob_op_t               req_op [$];
  logic [DATA_WIDTH-1:0] req_a [$];
  logic [DATA_WIDTH-1:0] req_b [$];
  logic [DATA_WIDTH-1:0] expected [$];

  // Output stall state, shared by driver and checker
  logic stall_active;
  logic saw_in_ready_low;
  int   stall_accepts;

  rob_subsystem #(
    .DATA_WIDTH (DATA_WIDTH),
    .ROB_DEPTH  (ROB_DEPTH)
  ) u_rob_subsystem (
    .clock          (clock),
    .resetn         (resetn),
    .in_valid       (in_valid),
    .in_opcode      (in_opcode),
    .in_operand_a   (in_operand_a),
    .in_operand_b   (in_operand_b),
    .out_ready      (out_ready),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .protocol_error (protocol_error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic load_stimulus();
    int                    fd;
    int                    count;
    string                 line;
    logic [1:0]            op_bits;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] r;
    fd = $fopen("rob_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file rob_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Header and blank lines do not scan as four fields
      count = $sscanf(line, "%h %h %h %h", op_bits, a, b, r);
      if (count == 4) begin
        req_op.push_back(rob_op_t'(op_bits));
        req_a.push_back(a);
        req_b.push_back(b);
        expected.push_back(r);
      end
    end
    $fclose(fd);
    if (expected.size() <= BURST_START) begin
      abort_run("Stimulus file holds too few requests");
    end
  endtask

  // Holds the current request until a negedge shows in_ready
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: a request was never accepted");
      end
    end while (!in_ready);
    if (stall_active) begin
      stall_accepts++;
    end
  endtask

  task automatic wait_for_stall();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: the output stall never started");
      end
    end while (!stall_active);
  endtask

  task automatic drive_requests();
    int gaps;
    for (int i = 0; i < req_op.size(); i++) begin
      gaps = 0;
      if (i < BURST_START) begin
        gaps = $urandom_range(0, 2);
      end else if (i == BURST_START) begin
        // Back-to-back burst into a stalled output
        @(posedge clock);
        in_valid <= 1'b0;
        wait_for_stall();
      end
      repeat (gaps) begin
        @(posedge clock);
        in_valid <= 1'b0;
      end
      @(posedge clock);
      in_valid     <= 1'b1;
      in_opcode    <= req_op[i];
      in_operand_a <= req_a[i];
      in_operand_b <= req_b[i];
      wait_accept();
    end
    @(posedge clock);
    in_valid <= 1'b0;
  endtask

  task automatic collect_results();
    int   received;
    int   idle;
    int   stall_left;
    logic stall_done;
    received   = 0;
    idle       = 0;
    stall_left = 0;
    stall_done = 1'b0;
    while (expected.size() > 0) begin
      @(posedge clock);
      if (!stall_active && !stall_done && received == BURST_START) begin
        stall_active = 1'b1;
        stall_left   = STALL_CYCLES;
      end else if (stall_active && stall_left == 0) begin
        stall_active = 1'b0;
        stall_done   = 1'b1;
        if (!saw_in_ready_low) begin
          abort_run("in_ready never dropped while the output was stalled");
        end
        if (stall_accepts > ROB_DEPTH) begin
          abort_run($sformatf("%0d requests accepted during the stall, more than %0d slots",
                              stall_accepts, ROB_DEPTH));
        end
      end
      if (stall_active) begin
        out_ready <= 1'b0;
        stall_left--;
      end else begin
        out_ready <= ($urandom_range(0, 3) != 0);
      end
      @(negedge clock);
      if (stall_active && !in_ready) begin
        saw_in_ready_low = 1'b1;
      end
      // Transfer happens on the coming edge
      if (out_valid && out_ready) begin
        check_result("out_result", expected.pop_front(), out_result);
        received++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          abort_run("Timeout: no result left the reorder buffer");
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'h3567));
    resetn           = 1'b0;
    in_valid         = 1'b0;
    in_opcode        = OP_ADD;
    in_operand_a     = '0;
    in_operand_b     = '0;
    out_ready        = 1'b0;
    stall_active     = 1'b0;
    saw_in_ready_low = 1'b0;
    stall_accepts    = 0;
    load_stimulus();
    repeat (16) @(posedge clock);
    resetn <= 1'b1;
    @(negedge clock);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("protocol_error", 1'b0, protocol_error);
    check_flag("in_ready", 1'b1, in_ready);
    fork
      drive_requests();
      collect_results();
    join
    // Nothing left over, nothing flagged
    @(posedge clock);
    out_ready <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge clock);
      check_flag("out_valid", 1'b0, out_valid);
      check_flag("protocol_error", 1'b0, protocol_error);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
